//--- sources.f
src/core_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/core_top.sv
tests/clock_gen.sv
tests/core_tb.sv

//--- src/core_pkg.sv
package core_pkg;

  localparam int REG_AW = 5;

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_src_e;

  typedef struct packed {
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    opcode_e           opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]       imm;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    opcode_e           opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]        imm_hi;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [4:0]        imm_lo;
    opcode_e           opcode;
  } s_fmt_t;

  typedef struct packed {
    logic              imm12;
    logic [5:0]        imm10_5;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [3:0]        imm4_1;
    logic              imm11;
    opcode_e           opcode;
  } b_fmt_t;

  // Same 32-bit word, four views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
  } instr_t;

endpackage

//--- src/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; #(
  parameter int IMEM_WORDS = 64,
  parameter int DMEM_WORDS = 64
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          start_i,
  input  logic                          imem_we_i,
  input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr_i,
  input  logic [31:0]                   imem_data_i,
  output logic                          wb_valid_o,
  output logic [REG_AW-1:0]             wb_rd_o,
  output logic [31:0]                   wb_data_o
);

  // Fetch to decode
  logic        if_valid;
  logic [31:0] if_pc;
  instr_t      if_instr;
  logic        stall;
  logic        redirect;
  logic [31:0] redirect_pc;

  // Decode to execute
  logic              id_valid;
  logic [31:0]       id_opa;
  logic [31:0]       id_opb;
  alu_op_e           id_alu_op;
  logic [31:0]       id_store_data;
  logic [REG_AW-1:0] id_rd;
  logic              id_reg_we;
  logic              id_mem_we;
  wb_src_e           id_wb_src;
  logic [31:0]       id_pc4;

  // Execute to result
  logic              ex_valid;
  logic [31:0]       ex_alu_result;
  logic [31:0]       ex_store_data;
  logic [REG_AW-1:0] ex_rd;
  logic              ex_reg_we;
  logic              ex_mem_we;
  wb_src_e           ex_wb_src;
  logic [31:0]       ex_pc4;

  // Pending destinations seen by the hazard check
  logic [REG_AW-1:0] pend_ex_rd;
  logic              pend_ex_we;
  logic [REG_AW-1:0] pend_mem_rd;
  logic              pend_mem_we;

  fetch_stage #(
    .IMEM_WORDS (IMEM_WORDS)
  ) fetch_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .start_i       (start_i),
    .imem_we_i     (imem_we_i),
    .imem_addr_i   (imem_addr_i),
    .imem_data_i   (imem_data_i),
    .stall_i       (stall),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .if_valid_o    (if_valid),
    .if_pc_o       (if_pc),
    .if_instr_o    (if_instr)
  );

  decode_stage decode_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .if_valid_i    (if_valid),
    .if_pc_i       (if_pc),
    .if_instr_i    (if_instr),
    .ex_rd_i       (pend_ex_rd),
    .ex_we_i       (pend_ex_we),
    .mem_rd_i      (pend_mem_rd),
    .mem_we_pend_i (pend_mem_we),
    .wb_valid_i    (wb_valid_o),
    .wb_rd_i       (wb_rd_o),
    .wb_data_i     (wb_data_o),
    .stall_o       (stall),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .id_valid_o    (id_valid),
    .opa_o         (id_opa),
    .opb_o         (id_opb),
    .alu_op_o      (id_alu_op),
    .store_data_o  (id_store_data),
    .rd_o          (id_rd),
    .reg_we_o      (id_reg_we),
    .mem_we_o      (id_mem_we),
    .wb_src_o      (id_wb_src),
    .pc4_o         (id_pc4)
  );

  execute_stage execute_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .id_valid_i      (id_valid),
    .id_opa_i        (id_opa),
    .id_opb_i        (id_opb),
    .id_alu_op_i     (id_alu_op),
    .id_store_data_i (id_store_data),
    .id_rd_i         (id_rd),
    .id_reg_we_i     (id_reg_we),
    .id_mem_we_i     (id_mem_we),
    .id_wb_src_i     (id_wb_src),
    .id_pc4_i        (id_pc4),
    .ex_rd_o         (pend_ex_rd),
    .ex_we_o         (pend_ex_we),
    .ex_valid_o      (ex_valid),
    .alu_result_o    (ex_alu_result),
    .store_data_o    (ex_store_data),
    .rd_o            (ex_rd),
    .reg_we_o        (ex_reg_we),
    .mem_we_o        (ex_mem_we),
    .wb_src_o        (ex_wb_src),
    .pc4_o           (ex_pc4)
  );

  result_stage #(
    .DMEM_WORDS (DMEM_WORDS)
  ) result_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .ex_valid_i      (ex_valid),
    .ex_alu_result_i (ex_alu_result),
    .ex_store_data_i (ex_store_data),
    .ex_rd_i         (ex_rd),
    .ex_reg_we_i     (ex_reg_we),
    .ex_mem_we_i     (ex_mem_we),
    .ex_wb_src_i     (ex_wb_src),
    .ex_pc4_i        (ex_pc4),
    .mem_rd_o        (pend_mem_rd),
    .mem_we_pend_o   (pend_mem_we),
    .wb_valid_o      (wb_valid_o),
    .wb_rd_o         (wb_rd_o),
    .wb_data_o       (wb_data_o)
  );

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              if_valid_i,
  input  logic [31:0]       if_pc_i,
  input  instr_t            if_instr_i,
  input  logic [REG_AW-1:0] ex_rd_i,
  input  logic              ex_we_i,
  input  logic [REG_AW-1:0] mem_rd_i,
  input  logic              mem_we_pend_i,
  input  logic              wb_valid_i,
  input  logic [REG_AW-1:0] wb_rd_i,
  input  logic [31:0]       wb_data_i,
  output logic              stall_o,
  output logic              redirect_o,
  output logic [31:0]       redirect_pc_o,
  output logic              id_valid_o,
  output logic [31:0]       opa_o,
  output logic [31:0]       opb_o,
  output alu_op_e           alu_op_o,
  output logic [31:0]       store_data_o,
  output logic [REG_AW-1:0] rd_o,
  output logic              reg_we_o,
  output logic              mem_we_o,
  output wb_src_e           wb_src_o,
  output logic [31:0]       pc4_o
);

  logic [31:0] regs [32];

  logic [REG_AW-1:0] rs1, rs2, rd;
  logic [2:0]  funct3;
  logic [31:0] rs1_val, rs2_val;
  logic [31:0] imm_i, imm_s, imm_b, imm_j, imm;
  alu_op_e     alu_op;
  wb_src_e     wb_src;
  logic        use_imm, use_rs1, use_rs2;
  logic        reg_we, mem_we, is_branch, is_jal;
  logic        hit_rs1, hit_rs2, taken, fire;

  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic sub);
    case (f3)
      3'b000:  return sub ? ALU_SUB : ALU_ADD;
      3'b010:  return ALU_SLT;
      3'b100:  return ALU_XOR;
      3'b110:  return ALU_OR;
      3'b111:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  // Read with write-through from write-back
  function automatic logic [31:0] rf_read(input logic [REG_AW-1:0] idx);
    if (idx == '0)
      return '0;
    if (wb_valid_i && wb_rd_i == idx)
      return wb_data_i;
    return regs[idx];
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (wb_valid_i && wb_rd_i != '0) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  assign rs1     = if_instr_i.r_fmt.rs1;
  assign rs2     = if_instr_i.r_fmt.rs2;
  assign rd      = if_instr_i.r_fmt.rd;
  assign funct3  = if_instr_i.r_fmt.funct3;
  assign rs1_val = rf_read(rs1);
  assign rs2_val = rf_read(rs2);

  assign imm_i = {{20{if_instr_i.i_fmt.imm[11]}}, if_instr_i.i_fmt.imm};
  assign imm_s = {{20{if_instr_i.s_fmt.imm_hi[6]}}, if_instr_i.s_fmt.imm_hi,
                  if_instr_i.s_fmt.imm_lo};
  assign imm_b = {{19{if_instr_i.b_fmt.imm12}}, if_instr_i.b_fmt.imm12,
                  if_instr_i.b_fmt.imm11, if_instr_i.b_fmt.imm10_5,
                  if_instr_i.b_fmt.imm4_1, 1'b0};
  // J-type bits sit in the I view's imm, rs1 and funct3 fields
  assign imm_j = {{11{if_instr_i.i_fmt.imm[11]}}, if_instr_i.i_fmt.imm[11],
                  if_instr_i.i_fmt.rs1, if_instr_i.i_fmt.funct3,
                  if_instr_i.i_fmt.imm[0], if_instr_i.i_fmt.imm[10:1], 1'b0};

  always_comb begin
    alu_op    = ALU_ADD;
    wb_src    = WB_ALU;
    imm       = imm_i;
    use_imm   = 1'b0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    reg_we    = 1'b0;
    mem_we    = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    case (if_instr_i.r_fmt.opcode)
      OP: begin
        alu_op  = alu_sel(funct3, if_instr_i.r_fmt.funct7[5]);
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        reg_we  = 1'b1;
      end
      OP_IMM: begin
        alu_op  = alu_sel(funct3, 1'b0);
        use_imm = 1'b1;
        use_rs1 = 1'b1;
        reg_we  = 1'b1;
      end
      LOAD: begin
        use_imm = 1'b1;
        use_rs1 = 1'b1;
        reg_we  = 1'b1;
        wb_src  = WB_MEM;
      end
      STORE: begin
        imm     = imm_s;
        use_imm = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1; // Store data
        mem_we  = 1'b1;
      end
      BRANCH: begin
        imm       = imm_b;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        is_branch = 1'b1;
      end
      JAL: begin
        imm    = imm_j;
        reg_we = 1'b1;
        wb_src = WB_PC4;
        is_jal = 1'b1;
      end
      default: ;
    endcase
  end

  // Wait for older writers still in execute or memory
  assign hit_rs1 = use_rs1 && rs1 != '0 &&
                   ((ex_we_i && ex_rd_i == rs1) || (mem_we_pend_i && mem_rd_i == rs1));
  assign hit_rs2 = use_rs2 && rs2 != '0 &&
                   ((ex_we_i && ex_rd_i == rs2) || (mem_we_pend_i && mem_rd_i == rs2));
  assign stall_o = if_valid_i && (hit_rs1 || hit_rs2);
  assign fire    = if_valid_i && !stall_o;

  assign taken = is_jal ||
                 (is_branch && (funct3[0] ? rs1_val != rs2_val : rs1_val == rs2_val));
  assign redirect_o    = fire && taken;
  assign redirect_pc_o = if_pc_i + imm;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      id_valid_o <= 1'b0;
      reg_we_o   <= 1'b0;
      mem_we_o   <= 1'b0;
    end else begin
      id_valid_o <= fire; // Bubble on stall
      reg_we_o   <= fire && reg_we;
      mem_we_o   <= fire && mem_we;
    end
  end

  always_ff @(posedge clk_i) begin
    opa_o        <= rs1_val;
    opb_o        <= use_imm ? imm : rs2_val;
    alu_op_o     <= alu_op;
    store_data_o <= rs2_val;
    rd_o         <= rd;
    wb_src_o     <= wb_src;
    pc4_o        <= if_pc_i + 32'd4;
  end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              id_valid_i,
  input  logic [31:0]       id_opa_i,
  input  logic [31:0]       id_opb_i,
  input  alu_op_e           id_alu_op_i,
  input  logic [31:0]       id_store_data_i,
  input  logic [REG_AW-1:0] id_rd_i,
  input  logic              id_reg_we_i,
  input  logic              id_mem_we_i,
  input  wb_src_e           id_wb_src_i,
  input  logic [31:0]       id_pc4_i,
  output logic [REG_AW-1:0] ex_rd_o,
  output logic              ex_we_o,
  output logic              ex_valid_o,
  output logic [31:0]       alu_result_o,
  output logic [31:0]       store_data_o,
  output logic [REG_AW-1:0] rd_o,
  output logic              reg_we_o,
  output logic              mem_we_o,
  output wb_src_e           wb_src_o,
  output logic [31:0]       pc4_o
);

  logic [31:0] alu_out;

  always_comb begin
    case (id_alu_op_i)
      ALU_ADD: alu_out = id_opa_i + id_opb_i;
      ALU_SUB: alu_out = id_opa_i - id_opb_i;
      ALU_AND: alu_out = id_opa_i & id_opb_i;
      ALU_OR:  alu_out = id_opa_i | id_opb_i;
      ALU_XOR: alu_out = id_opa_i ^ id_opb_i;
      ALU_SLT: alu_out = {31'd0, $signed(id_opa_i) < $signed(id_opb_i)};
      default: alu_out = '0;
    endcase
  end

  // Destination of the instruction now in execute
  assign ex_rd_o = id_rd_i;
  assign ex_we_o = id_valid_i && id_reg_we_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ex_valid_o <= 1'b0;
      reg_we_o   <= 1'b0;
      mem_we_o   <= 1'b0;
    end else begin
      ex_valid_o <= id_valid_i;
      reg_we_o   <= id_valid_i && id_reg_we_i;
      mem_we_o   <= id_valid_i && id_mem_we_i;
    end
  end

  always_ff @(posedge clk_i) begin
    alu_result_o <= alu_out;
    store_data_o <= id_store_data_i;
    rd_o         <= id_rd_i;
    wb_src_o     <= id_wb_src_i;
    pc4_o        <= id_pc4_i;
  end

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import core_pkg::*; #(
  parameter int IMEM_WORDS = 64
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          start_i,
  input  logic                          imem_we_i,
  input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr_i,
  input  logic [31:0]                   imem_data_i,
  input  logic                          stall_i,
  input  logic                          redirect_i,
  input  logic [31:0]                   redirect_pc_i,
  output logic                          if_valid_o,
  output logic [31:0]                   if_pc_o,
  output instr_t                        if_instr_o
);

  localparam int IA_W = $clog2(IMEM_WORDS);

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] pc;
  logic [IA_W-1:0] pc_idx;

  assign pc_idx = pc[IA_W+1:2]; // Word index

  // Loader port, only while the core is held
  always_ff @(posedge clk_i) begin
    if (!start_i && imem_we_i)
      imem[imem_addr_i] <= imem_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || !start_i) begin
      pc         <= '0;
      if_valid_o <= 1'b0;
    end else if (redirect_i) begin
      pc         <= redirect_pc_i;
      if_valid_o <= 1'b0; // Drop the wrong-path word
    end else if (!stall_i) begin
      pc         <= pc + 32'd4;
      if_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      if_pc_o    <= pc;
      if_instr_o <= imem[pc_idx];
    end
  end

endmodule

//--- src/result_stage.sv
`timescale 1ns/1ps

module result_stage import core_pkg::*; #(
  parameter int DMEM_WORDS = 64
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              ex_valid_i,
  input  logic [31:0]       ex_alu_result_i,
  input  logic [31:0]       ex_store_data_i,
  input  logic [REG_AW-1:0] ex_rd_i,
  input  logic              ex_reg_we_i,
  input  logic              ex_mem_we_i,
  input  wb_src_e           ex_wb_src_i,
  input  logic [31:0]       ex_pc4_i,
  output logic [REG_AW-1:0] mem_rd_o,
  output logic              mem_we_pend_o,
  output logic              wb_valid_o,
  output logic [REG_AW-1:0] wb_rd_o,
  output logic [31:0]       wb_data_o
);

  localparam int DA_W = $clog2(DMEM_WORDS);

  logic [31:0]     dmem [DMEM_WORDS];
  logic [DA_W-1:0] dmem_idx;
  logic [31:0]     load_data;
  logic [31:0]     wb_sel;

  assign dmem_idx  = ex_alu_result_i[DA_W+1:2]; // Word addressed
  assign load_data = dmem[dmem_idx];

  always_ff @(posedge clk_i) begin
    if (ex_valid_i && ex_mem_we_i)
      dmem[dmem_idx] <= ex_store_data_i;
  end

  always_comb begin
    case (ex_wb_src_i)
      WB_MEM:  wb_sel = load_data;
      WB_PC4:  wb_sel = ex_pc4_i;
      default: wb_sel = ex_alu_result_i;
    endcase
  end

  // Pending write for the decode hazard check
  assign mem_rd_o      = ex_rd_i;
  assign mem_we_pend_o = ex_valid_i && ex_reg_we_i;

  always_ff @(posedge clk_i) begin
    if (rst_i)
      wb_valid_o <= 1'b0;
    else
      wb_valid_o <= ex_valid_i && ex_reg_we_i && ex_rd_i != '0; // x0 never reported
  end

  always_ff @(posedge clk_i) begin
    wb_rd_o   <= ex_rd_i;
    wb_data_o <= wb_sel;
  end

endmodule

//--- tests/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o; // 10 ns period
  end

  initial begin
    rst_o = 1'b1;
    repeat (5) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- tests/core_tb.sv
`timescale 1ns/1ps

module core_tb;

  localparam int IMEM_WORDS = 64;
  localparam int N_ROWS     = 6;
  localparam int PROG_MAX   = 16;

  logic        clk;
  logic        por_rst;
  logic        row_rst;
  logic        start;
  logic        imem_we;
  logic [5:0]  imem_addr;
  logic [31:0] imem_data;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  // Program and expectation table
  logic [31:0] prog [N_ROWS][PROG_MAX];
  int          prog_len [N_ROWS];
  int          n_exp [N_ROWS];
  logic [4:0]  exp_rd [N_ROWS][PROG_MAX];
  logic [31:0] exp_data [N_ROWS][PROG_MAX];
  string       note [N_ROWS];

  int mismatch_count = 0;
  int fail_count     = 0;

  clock_gen clk_gen_i (
    .clk_o (clk),
    .rst_o (por_rst)
  );

  core_top #(
    .IMEM_WORDS (IMEM_WORDS),
    .DMEM_WORDS (64)
  ) dut_i (
    .clk_i       (clk),
    .rst_i       (por_rst || row_rst),
    .start_i     (start),
    .imem_we_i   (imem_we),
    .imem_addr_i (imem_addr),
    .imem_data_i (imem_data),
    .wb_valid_o  (wb_valid),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data)
  );

  // RV32I encodings
  function automatic logic [31:0] reg_op(input int f7, input int f3, input int rd,
                                         input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2,
                                         input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
            7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  task automatic add_word(input int r, input logic [31:0] w);
    prog[r][prog_len[r]] = w;
    prog_len[r]++;
  endtask

  task automatic expect_wb(input int r, input int rd, input logic [31:0] data);
    exp_rd[r][n_exp[r]]   = rd[4:0];
    exp_data[r][n_exp[r]] = data;
    n_exp[r]++;
  endtask

  // Word plus the write-back it must produce
  task automatic add_word_wb(input int r, input logic [31:0] w, input int rd,
                             input logic [31:0] data);
    add_word(r, w);
    expect_wb(r, rd, data);
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic fill_table();
    for (int r = 0; r < N_ROWS; r++) begin
      prog_len[r] = 0;
      n_exp[r]    = 0;
      for (int a = 0; a < PROG_MAX; a++)
        prog[r][a] = '0; // Opcode 0 decodes as nothing
    end
    note[0] = "ALU operations";
    add_word_wb(0, addi(1, 0, 7), 1, 32'd7);
    add_word_wb(0, addi(2, 0, -3), 2, 32'hFFFF_FFFD);
    add_word_wb(0, reg_op(7'h00, 3'b000, 3, 1, 2), 3, 32'd4);
    add_word_wb(0, reg_op(7'h20, 3'b000, 4, 1, 2), 4, 32'd10);
    add_word_wb(0, reg_op(7'h00, 3'b111, 5, 1, 2), 5, 32'd5);
    add_word_wb(0, reg_op(7'h00, 3'b110, 6, 1, 2), 6, 32'hFFFF_FFFF);
    add_word_wb(0, reg_op(7'h00, 3'b100, 7, 1, 2), 7, 32'hFFFF_FFFA);
    add_word_wb(0, reg_op(7'h00, 3'b010, 8, 2, 1), 8, 32'd1); // -3 < 7
    add_word_wb(0, reg_op(7'h00, 3'b010, 9, 1, 2), 9, 32'd0);
    add_word(0, jal(0, 0));
    note[1] = "dependent chain";
    add_word_wb(1, addi(1, 0, 1), 1, 32'd1);
    add_word_wb(1, addi(1, 1, 2), 1, 32'd3);
    add_word_wb(1, reg_op(7'h00, 3'b000, 2, 1, 1), 2, 32'd6);
    add_word_wb(1, reg_op(7'h20, 3'b000, 3, 2, 1), 3, 32'd3);
    add_word_wb(1, reg_op(7'h00, 3'b000, 3, 3, 2), 3, 32'd9);
    add_word_wb(1, reg_op(7'h00, 3'b100, 4, 3, 1), 4, 32'd10);
    add_word(1, jal(0, 0));
    note[2] = "stores and loads";
    add_word_wb(2, addi(1, 0, 'h55), 1, 32'h55);
    add_word_wb(2, addi(2, 0, -16), 2, 32'hFFFF_FFF0);
    add_word(2, sw(1, 0, 8));
    add_word(2, sw(2, 0, 12));
    add_word_wb(2, lw(3, 0, 8), 3, 32'h55);
    add_word_wb(2, lw(4, 0, 12), 4, 32'hFFFF_FFF0);
    add_word_wb(2, addi(5, 0, 4), 5, 32'd4);
    add_word_wb(2, lw(6, 5, 4), 6, 32'h55); // Address 8 again
    add_word(2, jal(0, 0));
    note[3] = "branches";
    add_word_wb(3, addi(1, 0, 5), 1, 32'd5);
    add_word_wb(3, addi(2, 0, 5), 2, 32'd5);
    add_word(3, branch(3'b000, 1, 2, 8));       // Taken so the next word is skipped
    add_word(3, addi(3, 0, 1));
    add_word(3, branch(3'b001, 1, 2, 8));       // Not taken
    add_word_wb(3, addi(4, 0, 2), 4, 32'd2);
    add_word(3, branch(3'b000, 1, 4, 8));       // Not taken
    add_word_wb(3, addi(5, 0, 3), 5, 32'd3);
    add_word(3, branch(3'b001, 1, 4, 8));       // Taken
    add_word(3, addi(6, 0, 4));
    add_word_wb(3, addi(7, 0, 6), 7, 32'd6);
    add_word(3, jal(0, 0));
    note[4] = "jump and link";
    add_word_wb(4, addi(1, 0, 1), 1, 32'd1);
    add_word_wb(4, jal(2, 12), 2, 32'd8); // Link is pc 4 + 4
    add_word(4, addi(3, 0, 9));
    add_word(4, addi(3, 0, 9));
    add_word_wb(4, reg_op(7'h00, 3'b000, 4, 2, 1), 4, 32'd9);
    add_word(4, jal(0, 0));
    note[5] = "register x0";
    add_word(5, addi(0, 0, 5));
    add_word_wb(5, addi(1, 0, 11), 1, 32'd11);
    add_word_wb(5, reg_op(7'h00, 3'b000, 2, 0, 1), 2, 32'd11);
    add_word_wb(5, reg_op(7'h00, 3'b000, 3, 1, 0), 3, 32'd11);
    add_word(5, reg_op(7'h20, 3'b000, 0, 1, 1));
    add_word(5, jal(0, 0));
  endtask

  task automatic run_row(input int r);
    int wait_cnt;
    $display("Row %0d: %s", r, note[r]);
    @(posedge clk);
    start   <= 1'b0;
    row_rst <= 1'b1;
    repeat (5) @(posedge clk);
    row_rst <= 1'b0;
    for (int a = 0; a < PROG_MAX; a++) begin
      imem_we   <= 1'b1;
      imem_addr <= a[5:0];
      imem_data <= prog[r][a];
      @(posedge clk);
    end
    imem_we <= 1'b0;
    start   <= 1'b1;
    for (int e = 0; e < n_exp[r]; e++) begin
      wait_cnt = 0;
      @(negedge clk);
      while (!wb_valid && wait_cnt < 200) begin
        @(negedge clk);
        wait_cnt++;
      end
      if (!wb_valid) begin
        $display("Timeout in row %0d waiting for write-back %0d", r, e);
        fail_count++;
        return;
      end
      check_eq(wb_rd, exp_rd[r][e], $sformatf("row %0d event %0d rd", r, e));
      check_eq(wb_data, exp_data[r][e], $sformatf("row %0d event %0d data", r, e));
    end
    // Program now spins on its final jump
    repeat (20) begin
      @(negedge clk);
      if (wb_valid) begin
        $display("Unexpected write-back in row %0d: x%0d = %h", r, wb_rd, wb_data);
        fail_count++;
      end
    end
  endtask

  initial begin
    int wait_cnt;
    row_rst   = 1'b0;
    start     = 1'b0;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    wait_cnt  = 0;
    fill_table();
    while (por_rst !== 1'b0 && wait_cnt < 20) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (por_rst !== 1'b0) begin
      $display("Power-on reset never released");
      fail_count++;
    end else begin
      for (int r = 0; r < N_ROWS; r++)
        run_row(r);
    end
    $display("Done: %0d mismatches, %0d other errors", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule
